// ==== sim.f ====
+incdir+.
agu_pkg.sv
bank_mask_gen.sv
tlb_array.sv
xlate_stage.sv
mop_queue.sv
mop_intake.sv
agu_top.sv
tb_agu.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS ?= --binary --timing --assert -j 0
TOP ?= tb_agu
FILELIST ?= sim.f
OBJ_DIR ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf $(OBJ_DIR)

// ==== tb_agu_model.svh ====
// testbench reference model: shadow TLB, bank run rule, fault rule and expected-result queue
`ifndef TB_AGU_MODEL_SVH
`define TB_AGU_MODEL_SVH

// shadow copy of the TLB, written on every fill
logic shadow_valid [TLB_ENTRIES];
logic [30:0] shadow_vpn [TLB_ENTRIES];
logic [30:0] shadow_ppn [TLB_ENTRIES];
logic shadow_sys [TLB_ENTRIES];
logic shadow_na [TLB_ENTRIES];

// expected results in acceptance order
logic [43:0] exp_paddr [$];
logic [31:0] exp_banks [$];
logic exp_miss [$];
logic [1:0] exp_fault [$];
logic [8:0] exp_tag [$];

task automatic shadow_fill(input int idx, input logic [30:0] vpn, input logic [30:0] ppn,
                           input logic sys, input logic na);
  shadow_valid[idx] = 1'b1;
  shadow_vpn[idx] = vpn;
  shadow_ppn[idx] = ppn;
  shadow_sys[idx] = sys;
  shadow_na[idx] = na;
endtask

// number of 4-byte banks touched, from the size table
function automatic int run_length(input logic [4:0] size, input logic [1:0] low);
  case (size)
    5'd16: return 1;
    5'd17: return (low == 2'd3) ? 2 : 1;
    5'd18, 5'd4, 5'd5, 5'd6: return (low != 2'd0) ? 2 : 1;
    5'd3: return (low == 2'd3) ? 4 : 3;
    5'd0, 5'd1, 5'd2, 5'd12, 5'd13, 5'd14: return (low != 2'd0) ? 5 : 4;
    5'd15: return 5;
    default: return (low != 2'd0) ? 3 : 2;
  endcase
endfunction

function automatic logic [31:0] expected_banks(input logic [4:0] size, input logic [43:0] va);
  logic [31:0] mask;
  int len;
  mask = '0;
  len = run_length(size, va[1:0]);
  for (int k = 0; k < len; k++) begin
    mask[(va[6:2] + k) % 32] = 1'b1;
  end
  return mask;
endfunction

task automatic predict_result(input logic [43:0] va, input logic [4:0] size,
                              input logic kernel, input logic [8:0] tag);
  int found;
  found = -1;
  for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
    if (shadow_valid[i] && shadow_vpn[i] == va[43:13]) found = i;
  end
  exp_tag.push_back(tag);
  if (found < 0) begin
    exp_miss.push_back(1'b1);
    exp_paddr.push_back('0);
    exp_banks.push_back('0);
    exp_fault.push_back(2'b00);
  end else begin
    exp_miss.push_back(1'b0);
    exp_paddr.push_back({shadow_ppn[found], va[12:0]});
    exp_banks.push_back(expected_banks(size, va));
    // bit 1 user on system page, bit 0 not accessible
    exp_fault.push_back({shadow_sys[found] && !kernel, shadow_na[found]});
  end
endtask

`endif

// ==== tb_agu.sv ====
// testbench for the data address stage: clock, reset, random stimulus, scoreboard and checks
`timescale 1ns/1ps

module tb_agu;

  localparam int QUEUE_DEPTH = 4;
  localparam int TLB_ENTRIES = 8;
  localparam int WAIT_LIMIT = 500;
  localparam logic [31:0] SEED = 32'hab89_3601;

  logic clk;
  logic rst;
  logic in_valid;
  logic [43:0] in_vaddr;
  logic [4:0] in_size;
  logic in_kernel;
  logic [8:0] in_tag;
  logic in_ready;
  logic fill_en;
  logic [2:0] fill_idx;
  logic [30:0] fill_vpn;
  logic [30:0] fill_ppn;
  logic fill_sys;
  logic fill_na;
  logic res_valid;
  logic [43:0] res_paddr;
  logic [31:0] res_banks;
  logic res_miss;
  logic [1:0] res_fault;
  logic [8:0] res_tag;
  logic res_ready;

  int errors = 0;
  int checks = 0;
  // 0 always ready, 1 held low, 2 random
  int ready_mode = 0;
  logic [8:0] next_tag = '0;
  logic [30:0] page_vpn [TLB_ENTRIES];

  // state for the held-result check
  logic was_held = 1'b0;
  logic [43:0] held_paddr;
  logic [31:0] held_banks;
  logic held_miss;
  logic [1:0] held_fault;
  logic [8:0] held_tag;

  `include "tb_agu_model.svh"

  agu_top #(.QUEUE_DEPTH(QUEUE_DEPTH), .TLB_ENTRIES(TLB_ENTRIES)) uut (
    .clk(clk), .rst(rst),
    .in_valid(in_valid), .in_vaddr(in_vaddr), .in_size(in_size),
    .in_kernel(in_kernel), .in_tag(in_tag), .in_ready(in_ready),
    .fill_en(fill_en), .fill_idx(fill_idx), .fill_vpn(fill_vpn),
    .fill_ppn(fill_ppn), .fill_sys(fill_sys), .fill_na(fill_na),
    .res_valid(res_valid), .res_paddr(res_paddr), .res_banks(res_banks),
    .res_miss(res_miss), .res_fault(res_fault), .res_tag(res_tag),
    .res_ready(res_ready)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    #1;
    if (ready_mode == 0) res_ready = 1'b1;
    else if (ready_mode == 1) res_ready = 1'b0;
    else res_ready = 1'($urandom_range(1, 0));
  end

  task automatic finish_run();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  endtask

  task automatic report_timeout(input string what);
    $display("timeout while waiting for %s", what);
    errors++;
    finish_run();
  endtask

  task automatic compare_result();
    if (exp_tag.size() == 0) begin
      $display("result at %0t with no operation pending", $time);
      errors++;
    end else begin
      checks++;
      assert (res_tag === exp_tag[0] && res_miss === exp_miss[0] &&
              res_paddr === exp_paddr[0] && res_banks === exp_banks[0] &&
              res_fault === exp_fault[0]) else begin
        $display("[FAIL] %0t tag %h miss %b paddr %h banks %h fault %b, expected %h %b %h %h %b",
                 $time, res_tag, res_miss, res_paddr, res_banks, res_fault, exp_tag[0],
                 exp_miss[0], exp_paddr[0], exp_banks[0], exp_fault[0]);
        errors++;
      end
      void'(exp_tag.pop_front());
      void'(exp_miss.pop_front());
      void'(exp_paddr.pop_front());
      void'(exp_banks.pop_front());
      void'(exp_fault.pop_front());
    end
  endtask

  // scoreboard samples mid-cycle where everything is stable
  always @(negedge clk) begin
    if (!rst) begin
      if (was_held) begin
        checks++;
        assert (res_valid && res_paddr === held_paddr && res_banks === held_banks &&
                res_miss === held_miss && res_fault === held_fault &&
                res_tag === held_tag) else begin
          $display("[FAIL] %0t held result changed under back-pressure", $time);
          errors++;
        end
      end
      if (in_valid && in_ready) predict_result(in_vaddr, in_size, in_kernel, in_tag);
      if (res_valid && res_ready) compare_result();
      was_held = res_valid && !res_ready;
      held_paddr = res_paddr;
      held_banks = res_banks;
      held_miss = res_miss;
      held_fault = res_fault;
      held_tag = res_tag;
    end
  end

  task automatic drain_results();
    int waited;
    waited = 0;
    while (exp_tag.size() != 0 || res_valid) begin
      waited++;
      if (waited > WAIT_LIMIT) report_timeout("outstanding results to drain");
      @(posedge clk);
      #1;
    end
  endtask

  task automatic fill_entry(input int idx, input logic [30:0] vpn, input logic [30:0] ppn,
                            input logic sys, input logic na);
    drain_results();
    fill_en = 1'b1;
    fill_idx = idx[2:0];
    fill_vpn = vpn;
    fill_ppn = ppn;
    fill_sys = sys;
    fill_na = na;
    shadow_fill(idx, vpn, ppn, sys, na);
    @(posedge clk);
    #1;
    fill_en = 1'b0;
  endtask

  task automatic set_op(input logic [43:0] va, input logic [4:0] size, input logic kernel);
    in_vaddr = va;
    in_size = size;
    in_kernel = kernel;
    in_tag = next_tag;
    next_tag++;
  endtask

  task automatic send_op(input logic [43:0] va, input logic [4:0] size, input logic kernel);
    int waited;
    waited = 0;
    set_op(va, size, kernel);
    in_valid = 1'b1;
    @(negedge clk);
    while (!in_ready) begin
      waited++;
      if (waited > WAIT_LIMIT) report_timeout("in_ready");
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    in_valid = 1'b0;
  endtask

  function automatic logic [43:0] random_addr(input int page);
    return {page_vpn[page], 13'($urandom)};
  endfunction

  task automatic random_ops(input int count, input int pages);
    for (int n = 0; n < count; n++) begin
      send_op(random_addr($urandom_range(pages - 1, 0)), 5'($urandom), 1'($urandom));
    end
  endtask

  initial begin
    int accepted;
    logic fell;
    void'($urandom(SEED));
    rst = 1'b1;
    in_valid = 1'b0;
    in_vaddr = '0;
    in_size = '0;
    in_kernel = 1'b0;
    in_tag = '0;
    fill_en = 1'b0;
    fill_idx = '0;
    fill_vpn = '0;
    fill_ppn = '0;
    fill_sys = 1'b0;
    fill_na = 1'b0;
    res_ready = 1'b1;
    for (int i = 0; i < TLB_ENTRIES; i++) shadow_valid[i] = 1'b0;

    // reset checked from the first edge on
    for (int c = 0; c < 5; c++) begin
      @(posedge clk);
      #1;
      if (c == 3) rst = 1'b0;
      checks++;
      assert (!res_valid && in_ready) else begin
        $display("[FAIL] %0t res_valid %b in_ready %b around reset", $time, res_valid, in_ready);
        errors++;
      end
    end

    // pages 0..5 plain, 6 system, 7 not accessible
    for (int i = 0; i < TLB_ENTRIES; i++) begin
      page_vpn[i] = {16'($urandom), 4'(i), 11'($urandom)};
      fill_entry(i, page_vpn[i], 31'($urandom), i == 6, i == 7);
    end
    random_ops(60, 6);

    // every size code and alignment near the wrap point
    for (int b = 29; b < 32; b++) begin
      for (int s = 0; s < 32; s++) begin
        for (int l = 0; l < 4; l++) begin
          send_op({page_vpn[1], 6'($urandom), 5'(b), 2'(l)}, 5'(s), 1'b0);
        end
      end
    end

    // unfilled page then a refill replacing index 0
    send_op({page_vpn[0] ^ 31'h4000_0000, 13'h0123}, 5'd18, 1'b0);
    drain_results();
    fill_entry(0, page_vpn[0] ^ 31'h2000_0000, 31'($urandom), 1'b0, 1'b0);
    send_op({page_vpn[0], 13'h0040}, 5'd18, 1'b0);
    page_vpn[0] = page_vpn[0] ^ 31'h2000_0000;
    send_op(random_addr(0), 5'd19, 1'b0);

    // faults on system and na pages for both privileges
    for (int k = 0; k < 2; k++) begin
      send_op(random_addr(6), 5'd18, k[0]);
      send_op(random_addr(7), 5'd16, k[0]);
    end
    drain_results();

    // back-pressure
    ready_mode = 1;
    @(posedge clk);
    #1;
    accepted = 0;
    fell = 1'b0;
    set_op(random_addr(2), 5'd16, 1'b0);
    in_valid = 1'b1;
    for (int c = 0; c < 20 && !fell; c++) begin
      @(negedge clk);
      if (!in_ready) begin
        fell = 1'b1;
      end else begin
        accepted++;
        @(posedge clk);
        #1;
        set_op(random_addr(3), 5'($urandom), 1'($urandom));
      end
    end
    @(posedge clk);
    #1;
    in_valid = 1'b0;
    if (!fell) begin
      report_timeout("in_ready to fall under back-pressure");
    end else begin
      checks++;
      assert (accepted <= QUEUE_DEPTH + 1) else begin
        $display("[FAIL] %0t %0d operations accepted while stalled", $time, accepted);
        errors++;
      end
    end
    repeat (8) @(posedge clk);
    #1;
    ready_mode = 2;
    random_ops(80, 8);
    drain_results();
    finish_run();
  end

endmodule

// ==== agu_top.sv ====
// top level of the data address stage: intake, operation queue and translation stage
`timescale 1ns/1ps

module agu_top #(
  parameter int QUEUE_DEPTH = 4,
  parameter int TLB_ENTRIES = 8
) (
  input  logic clk,
  input  logic rst,
  input  logic in_valid,
  input  logic [agu_pkg::VADDR_W-1:0] in_vaddr,
  input  logic [agu_pkg::SIZE_W-1:0] in_size,
  input  logic in_kernel,
  input  logic [agu_pkg::TAG_W-1:0] in_tag,
  output logic in_ready,
  input  logic fill_en,
  input  logic [((TLB_ENTRIES > 1) ? $clog2(TLB_ENTRIES) : 1)-1:0] fill_idx,
  input  logic [agu_pkg::VPN_W-1:0] fill_vpn,
  input  logic [agu_pkg::PPN_W-1:0] fill_ppn,
  input  logic fill_sys,
  input  logic fill_na,
  output logic res_valid,
  output logic [agu_pkg::PADDR_W-1:0] res_paddr,
  output logic [agu_pkg::BANK_COUNT-1:0] res_banks,
  output logic res_miss,
  output logic [agu_pkg::FAULT_W-1:0] res_fault,
  output logic [agu_pkg::TAG_W-1:0] res_tag,
  input  logic res_ready
);

  // intake to queue
  logic push;
  logic [agu_pkg::VADDR_W-1:0] q_vaddr;
  logic [agu_pkg::SIZE_W-1:0] q_size;
  logic q_kernel;
  logic [agu_pkg::TAG_W-1:0] q_tag;

  // queue head to translation
  logic head_valid;
  logic [agu_pkg::VADDR_W-1:0] head_vaddr;
  logic [agu_pkg::SIZE_W-1:0] head_size;
  logic head_kernel;
  logic [agu_pkg::TAG_W-1:0] head_tag;
  // pop doubles as the credit return
  logic pop;

  mop_intake #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_intake (
    .clk(clk), .rst(rst),
    .in_valid(in_valid), .in_vaddr(in_vaddr), .in_size(in_size),
    .in_kernel(in_kernel), .in_tag(in_tag), .credit(pop),
    .in_ready(in_ready), .push(push),
    .q_vaddr(q_vaddr), .q_size(q_size), .q_kernel(q_kernel), .q_tag(q_tag)
  );

  mop_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_queue (
    .clk(clk), .rst(rst),
    .push(push), .push_vaddr(q_vaddr), .push_size(q_size),
    .push_kernel(q_kernel), .push_tag(q_tag), .pop(pop),
    .head_valid(head_valid), .head_vaddr(head_vaddr), .head_size(head_size),
    .head_kernel(head_kernel), .head_tag(head_tag)
  );

  xlate_stage #(.TLB_ENTRIES(TLB_ENTRIES)) u_xlate (
    .clk(clk), .rst(rst),
    .head_valid(head_valid), .head_vaddr(head_vaddr), .head_size(head_size),
    .head_kernel(head_kernel), .head_tag(head_tag),
    .fill_en(fill_en), .fill_idx(fill_idx), .fill_vpn(fill_vpn),
    .fill_ppn(fill_ppn), .fill_sys(fill_sys), .fill_na(fill_na),
    .res_ready(res_ready), .pop(pop),
    .res_valid(res_valid), .res_paddr(res_paddr), .res_banks(res_banks),
    .res_miss(res_miss), .res_fault(res_fault), .res_tag(res_tag)
  );

endmodule

// ==== mop_intake.sv ====
// operation intake: credit counter and one-entry input register feeding the queue
`timescale 1ns/1ps

module mop_intake #(
  parameter int QUEUE_DEPTH = 4
) (
  input  logic clk,
  input  logic rst,
  input  logic in_valid,
  input  logic [agu_pkg::VADDR_W-1:0] in_vaddr,
  input  logic [agu_pkg::SIZE_W-1:0] in_size,
  input  logic in_kernel,
  input  logic [agu_pkg::TAG_W-1:0] in_tag,
  input  logic credit,
  output logic in_ready,
  output logic push,
  output logic [agu_pkg::VADDR_W-1:0] q_vaddr,
  output logic [agu_pkg::SIZE_W-1:0] q_size,
  output logic q_kernel,
  output logic [agu_pkg::TAG_W-1:0] q_tag
);

  localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

  logic [CNT_W-1:0] credits;
  logic accept;

  // one free queue slot per credit
  assign in_ready = (credits != '0);
  assign accept = in_valid && in_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      credits <= CNT_W'(QUEUE_DEPTH);
      push <= 1'b0;
    end else begin
      push <= accept;
      // spend and return in the same cycle cancel out
      if (accept && !credit) begin
        credits <= credits - CNT_W'(1);
      end else if (!accept && credit) begin
        credits <= credits + CNT_W'(1);
      end
    end
  end

  // input register, pushed on the following edge
  always_ff @(posedge clk) begin
    if (accept) begin
      q_vaddr <= in_vaddr;
      q_size <= in_size;
      q_kernel <= in_kernel;
      q_tag <= in_tag;
    end
  end

endmodule

// ==== mop_queue.sv ====
// circular FIFO of memory operations with read/write pointers and occupancy count
`timescale 1ns/1ps

module mop_queue #(
  parameter int QUEUE_DEPTH = 4
) (
  input  logic clk,
  input  logic rst,
  input  logic push,
  input  logic [agu_pkg::VADDR_W-1:0] push_vaddr,
  input  logic [agu_pkg::SIZE_W-1:0] push_size,
  input  logic push_kernel,
  input  logic [agu_pkg::TAG_W-1:0] push_tag,
  input  logic pop,
  output logic head_valid,
  output logic [agu_pkg::VADDR_W-1:0] head_vaddr,
  output logic [agu_pkg::SIZE_W-1:0] head_size,
  output logic head_kernel,
  output logic [agu_pkg::TAG_W-1:0] head_tag
);

  localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
  localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);
  localparam logic [PTR_W-1:0] LAST = PTR_W'(QUEUE_DEPTH - 1);

  logic [agu_pkg::VADDR_W-1:0] mem_vaddr [QUEUE_DEPTH];
  logic [agu_pkg::SIZE_W-1:0] mem_size [QUEUE_DEPTH];
  logic mem_kernel [QUEUE_DEPTH];
  logic [agu_pkg::TAG_W-1:0] mem_tag [QUEUE_DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;

  // head is visible the cycle after its push
  assign head_valid = (count != '0);
  assign head_vaddr = mem_vaddr[rd_ptr];
  assign head_size = mem_size[rd_ptr];
  assign head_kernel = mem_kernel[rd_ptr];
  assign head_tag = mem_tag[rd_ptr];

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      // no full check, the intake credits keep pushes in bounds
      if (push) begin
        wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + PTR_W'(1);
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + PTR_W'(1);
      end
      if (push && !pop) begin
        count <= count + CNT_W'(1);
      end else if (pop && !push) begin
        count <= count - CNT_W'(1);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem_vaddr[wr_ptr] <= push_vaddr;
      mem_size[wr_ptr] <= push_size;
      mem_kernel[wr_ptr] <= push_kernel;
      mem_tag[wr_ptr] <= push_tag;
    end
  end

endmodule

// ==== xlate_stage.sv ====
// translation stage: pop control, TLB lookup, bank mask, fault check and result register
`timescale 1ns/1ps

module xlate_stage #(
  parameter int TLB_ENTRIES = 8
) (
  input  logic clk,
  input  logic rst,
  input  logic head_valid,
  input  logic [agu_pkg::VADDR_W-1:0] head_vaddr,
  input  logic [agu_pkg::SIZE_W-1:0] head_size,
  input  logic head_kernel,
  input  logic [agu_pkg::TAG_W-1:0] head_tag,
  input  logic fill_en,
  input  logic [((TLB_ENTRIES > 1) ? $clog2(TLB_ENTRIES) : 1)-1:0] fill_idx,
  input  logic [agu_pkg::VPN_W-1:0] fill_vpn,
  input  logic [agu_pkg::PPN_W-1:0] fill_ppn,
  input  logic fill_sys,
  input  logic fill_na,
  input  logic res_ready,
  output logic pop,
  output logic res_valid,
  output logic [agu_pkg::PADDR_W-1:0] res_paddr,
  output logic [agu_pkg::BANK_COUNT-1:0] res_banks,
  output logic res_miss,
  output logic [agu_pkg::FAULT_W-1:0] res_fault,
  output logic [agu_pkg::TAG_W-1:0] res_tag
);

  logic hit;
  logic [agu_pkg::PPN_W-1:0] hit_ppn;
  logic hit_sys;
  logic hit_na;
  logic [agu_pkg::BANK_COUNT-1:0] banks;
  logic [agu_pkg::FAULT_W-1:0] fault;

  tlb_array #(.TLB_ENTRIES(TLB_ENTRIES)) u_tlb (
    .clk(clk), .rst(rst),
    .lookup_vpn(head_vaddr[agu_pkg::VADDR_W-1:agu_pkg::PAGE_BITS]),
    .fill_en(fill_en), .fill_idx(fill_idx), .fill_vpn(fill_vpn),
    .fill_ppn(fill_ppn), .fill_sys(fill_sys), .fill_na(fill_na),
    .hit(hit), .hit_ppn(hit_ppn), .hit_sys(hit_sys), .hit_na(hit_na)
  );

  bank_mask_gen u_banks (
    .size(head_size),
    .addr_low(head_vaddr[1:0]),
    .bank0(head_vaddr[agu_pkg::BANK_LSB +: agu_pkg::BANK_W]),
    .banks(banks)
  );

  // take the head when the result slot is free or draining this cycle
  assign pop = head_valid && (!res_valid || res_ready);

  always_comb begin
    fault = '0;
    fault[agu_pkg::FAULT_SYS] = hit_sys && !head_kernel;
    fault[agu_pkg::FAULT_NA] = hit_na;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      res_valid <= 1'b0;
    end else if (pop) begin
      res_valid <= 1'b1;
    end else if (res_ready) begin
      res_valid <= 1'b0;
    end
  end

  // result payload, held while the consumer stalls
  always_ff @(posedge clk) begin
    if (pop) begin
      res_tag <= head_tag;
      res_miss <= !hit;
      if (hit) begin
        res_paddr <= {hit_ppn, head_vaddr[agu_pkg::PAGE_BITS-1:0]};
        res_banks <= banks;
        res_fault <= fault;
      end else begin
        // a miss carries no access
        res_paddr <= '0;
        res_banks <= '0;
        res_fault <= '0;
      end
    end
  end

endmodule

// ==== tlb_array.sv ====
// fully associative data TLB with indexed fill and lowest-index lookup
`timescale 1ns/1ps

module tlb_array #(
  parameter int TLB_ENTRIES = 8
) (
  input  logic clk,
  input  logic rst,
  input  logic [agu_pkg::VPN_W-1:0] lookup_vpn,
  input  logic fill_en,
  input  logic [((TLB_ENTRIES > 1) ? $clog2(TLB_ENTRIES) : 1)-1:0] fill_idx,
  input  logic [agu_pkg::VPN_W-1:0] fill_vpn,
  input  logic [agu_pkg::PPN_W-1:0] fill_ppn,
  input  logic fill_sys,
  input  logic fill_na,
  output logic hit,
  output logic [agu_pkg::PPN_W-1:0] hit_ppn,
  output logic hit_sys,
  output logic hit_na
);

  logic [TLB_ENTRIES-1:0] valid;
  logic [agu_pkg::VPN_W-1:0] vpn [TLB_ENTRIES];
  logic [agu_pkg::PPN_W-1:0] ppn [TLB_ENTRIES];
  logic [TLB_ENTRIES-1:0] sys;
  logic [TLB_ENTRIES-1:0] na;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid <= '0;
    end else if (fill_en) begin
      valid[fill_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (fill_en) begin
      vpn[fill_idx] <= fill_vpn;
      ppn[fill_idx] <= fill_ppn;
      sys[fill_idx] <= fill_sys;
      na[fill_idx] <= fill_na;
    end
  end

  // scan downwards so the lowest matching entry wins
  always_comb begin
    hit = 1'b0;
    hit_ppn = '0;
    hit_sys = 1'b0;
    hit_na = 1'b0;
    for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
      if (valid[i] && vpn[i] == lookup_vpn) begin
        hit = 1'b1;
        hit_ppn = ppn[i];
        hit_sys = sys[i];
        hit_na = na[i];
      end
    end
  end

endmodule

// ==== bank_mask_gen.sv ====
// size code decode and wrapping bank run mask
`timescale 1ns/1ps

module bank_mask_gen (
  input  logic [agu_pkg::SIZE_W-1:0] size,
  input  logic [1:0] addr_low,
  input  logic [agu_pkg::BANK_W-1:0] bank0,
  output logic [agu_pkg::BANK_COUNT-1:0] banks
);

  logic [2:0] size_class;
  logic [agu_pkg::BANK_W-1:0] run_len;
  logic [agu_pkg::BANK_W-1:0] offset;
  logic step;
  logic step3;

  // any misalignment, or misaligned by three bytes
  assign step = |addr_low;
  assign step3 = &addr_low;

  always_comb begin
    case (size)
      agu_pkg::SZ_BYTE: size_class = agu_pkg::CLS_1;
      agu_pkg::SZ_HALF: size_class = agu_pkg::CLS_2;
      agu_pkg::SZ_WORD: size_class = agu_pkg::CLS_4;
      agu_pkg::SZ_DWORD: size_class = agu_pkg::CLS_8;
      agu_pkg::SZ_EXT: size_class = agu_pkg::CLS_10;
      agu_pkg::SZ_SPILL: size_class = agu_pkg::CLS_20;
      // 32-bit float forms
      5'd4, 5'd5, 5'd6: size_class = agu_pkg::CLS_4;
      // 128-bit vectors, unaligned and aligned
      5'd0, 5'd1, 5'd2, 5'd12, 5'd13, 5'd14: size_class = agu_pkg::CLS_16;
      // 64-bit forms and anything unlisted
      default: size_class = agu_pkg::CLS_8;
    endcase
  end

  always_comb begin
    case (size_class)
      agu_pkg::CLS_1: run_len = 5'd1;
      agu_pkg::CLS_2: run_len = step3 ? 5'd2 : 5'd1;
      agu_pkg::CLS_4: run_len = step ? 5'd2 : 5'd1;
      agu_pkg::CLS_10: run_len = step3 ? 5'd4 : 5'd3;
      agu_pkg::CLS_16: run_len = step ? 5'd5 : 5'd4;
      agu_pkg::CLS_20: run_len = 5'd5;
      default: run_len = step ? 5'd3 : 5'd2;
    endcase
  end

  // distance from bank0 modulo the bank count gives the wrap
  always_comb begin
    offset = '0;
    for (int i = 0; i < agu_pkg::BANK_COUNT; i++) begin
      offset = agu_pkg::BANK_W'(i) - bank0;
      banks[i] = (offset < run_len);
    end
  end

endmodule

// ==== agu_pkg.sv ====
// address widths, bank geometry, size codes and fault bit positions for the data address stage
package agu_pkg;

  // virtual side
  localparam int VADDR_W = 44;
  // 8 KiB pages
  localparam int PAGE_BITS = 13;
  localparam int VPN_W = VADDR_W - PAGE_BITS;

  // physical side
  localparam int PADDR_W = 44;
  localparam int PPN_W = PADDR_W - PAGE_BITS;

  // cache banks, 4 bytes each
  localparam int BANK_COUNT = 32;
  localparam int BANK_W = 5;
  // lowest address bit of the bank index
  localparam int BANK_LSB = 2;

  // operation fields
  localparam int SIZE_W = 5;
  localparam int TAG_W = 9;

  // integer size codes
  localparam logic [SIZE_W-1:0] SZ_BYTE = 5'd16;
  localparam logic [SIZE_W-1:0] SZ_HALF = 5'd17;
  localparam logic [SIZE_W-1:0] SZ_WORD = 5'd18;
  localparam logic [SIZE_W-1:0] SZ_DWORD = 5'd19;

  // 80-bit extended float, 10 bytes
  localparam logic [SIZE_W-1:0] SZ_EXT = 5'd3;
  // 160-bit fill/spill, always 5 banks
  localparam logic [SIZE_W-1:0] SZ_SPILL = 5'd15;

  // size classes, one per run-length rule
  localparam logic [2:0] CLS_1 = 3'd0;
  localparam logic [2:0] CLS_2 = 3'd1;
  localparam logic [2:0] CLS_4 = 3'd2;
  localparam logic [2:0] CLS_8 = 3'd3;
  localparam logic [2:0] CLS_10 = 3'd4;
  localparam logic [2:0] CLS_16 = 3'd5;
  localparam logic [2:0] CLS_20 = 3'd6;

  // page fault code
  localparam int FAULT_W = 2;
  // user access to a system page
  localparam int FAULT_SYS = 1;
  // page marked not accessible
  localparam int FAULT_NA = 0;

endpackage
